// File: shapi_cfg.svh
// widths, address map and identity words of the SHAPI register block
`ifndef SHAPI_CFG_SVH
`define SHAPI_CFG_SVH

// --------------------------------------------------
// widths and address map
// --------------------------------------------------
`define SHAPI_ADDR_W        11              // word address
`define SHAPI_DATA_W        32
`define SHAPI_BE_W          4
`define SHAPI_MOD_DMA_OFF   11'h040         // base of dma module space
`define SHAPI_NUM_BUF       8               // buffer host addresses
`define SHAPI_DMA_SIZE_W    21
`define SHAPI_TRIG_CH       4
`define SHAPI_TRIG_W        16
`define SHAPI_SCRATCH_RST   32'h0000_00BB

// --------------------------------------------------
// standard device identity
// --------------------------------------------------
`define SHAPI_DEV_MAGIC     32'h5348_0100   // "SH", major 1 minor 0
`define SHAPI_DEV_VERSION   32'h0000_0040   // next block at module space
`define SHAPI_DEV_HW_ID     32'h0001_0ee1   // hw id / vendor
`define SHAPI_DEV_FW_ID     32'h0002_0ee1   // fw id / vendor
`define SHAPI_DEV_FW_VER    32'h0001_0203   // major.minor.patch
`define SHAPI_DEV_TSTAMP    32'h5cc6_f000
`define SHAPI_DEV_NAME1     32'h5043_4945   // "PCIE"
`define SHAPI_DEV_NAME2     32'h5f44_4d41   // "_DMA"
`define SHAPI_DEV_NAME3     32'h5f45_5030   // "_EP0"
`define SHAPI_DEV_CAPAB     32'h4000_0000   // {full, soft, 28'h0, rtm, endian}

// --------------------------------------------------
// dma module identity
// --------------------------------------------------
`define SHAPI_MOD_MAGIC     32'h5346_0100   // "SF", major 1 minor 0
`define SHAPI_MOD_VERSION   32'h0000_0000   // last module in chain
`define SHAPI_MOD_FW_ID     32'h0003_0ee1
`define SHAPI_MOD_FW_VER    32'h0001_0000
`define SHAPI_MOD_NAME1     32'h444d_415f   // "DMA_"
`define SHAPI_MOD_NAME2     32'h4348_3031   // "CH01"
`define SHAPI_MOD_CAPAB     32'h4000_0001   // soft reset, multi interrupt
`define SHAPI_MOD_INT_ID    32'h0000_0010
`define SHAPI_MOD_MAX_BYTES 32'h0010_0000   // 1 MiB per buffer
`define SHAPI_MOD_TLP_PLD   32'h0000_0080   // 128 byte payload

`endif

// File: shapi_pkg.sv
// address, data, byte-enable and write-state types of the SHAPI register block
`include "shapi_cfg.svh"

package shapi_pkg;

    typedef logic [`SHAPI_ADDR_W-1:0] shapi_addr_t;    // register word address
    typedef logic [`SHAPI_DATA_W-1:0] shapi_data_t;    // register word
    typedef logic [`SHAPI_BE_W-1:0]   shapi_be_t;      // byte enables

    // write path states
    typedef enum logic [1:0]
    {
        WR_IDLE   = 2'b00,  // waiting for strobe
        WR_MERGE  = 2'b01,  // form merged word
        WR_COMMIT = 2'b10   // target register loads
    } shapi_wr_state_t;

endpackage

// File: shapi_write_ctrl.sv
// write FSM with capture, byte-lane merge, busy flag and commit strobe
`timescale 1ns/1ps
`include "shapi_cfg.svh"

module shapi_write_ctrl
    import shapi_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en_i,
    input  shapi_addr_t wr_addr_i,
    input  shapi_be_t   wr_be_i,
    input  shapi_data_t wr_data_i,
    output logic        wr_busy_o,
    output logic        commit_o,
    output shapi_addr_t commit_addr_o,
    output shapi_data_t commit_data_o
);

    shapi_wr_state_t state;
    shapi_addr_t     cap_addr;   // captured on accept
    shapi_be_t       cap_be;
    shapi_data_t     cap_data;
    shapi_data_t     merged;

    // --------------------------------------------------
    // byte-lane merge of the byte reversed payload
    // --------------------------------------------------
    // pre-read word is always zero so a disabled lane drops to zero
    assign merged = {cap_be[3] ? cap_data[7:0]   : 8'h00,
                     cap_be[2] ? cap_data[15:8]  : 8'h00,
                     cap_be[1] ? cap_data[23:16] : 8'h00,
                     cap_be[0] ? cap_data[31:24] : 8'h00};

    assign wr_busy_o     = wr_en_i | (state != WR_IDLE);
    assign commit_addr_o = cap_addr;    // stable from accept to commit

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= WR_IDLE;
            commit_o <= 1'b0;
        end
        else
        begin
            case (state)
                WR_IDLE:
                begin
                    commit_o <= 1'b0;
                    if (wr_en_i)
                        state <= WR_MERGE;   // accept edge
                end
                WR_MERGE:
                begin
                    commit_o <= 1'b1;        // one cycle strobe
                    state    <= WR_COMMIT;
                end
                WR_COMMIT:
                begin
                    commit_o <= 1'b0;        // spaces load on this edge
                    state    <= WR_IDLE;
                end
                default:
                begin
                    commit_o <= 1'b0;
                    state    <= WR_IDLE;
                end
            endcase
        end
    end

    // capture on accept and merged word in the merge state
    always_ff @(posedge clk)
    begin
        if (state == WR_IDLE && wr_en_i)
        begin
            cap_addr <= wr_addr_i;
            cap_be   <= wr_be_i;
            cap_data <= wr_data_i;
        end
        if (state == WR_MERGE)
            commit_data_o <= merged;
    end

    // strobe never stretches, so a space sees each write exactly once
    a_commit_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        commit_o |=> !commit_o);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {WR_IDLE, WR_MERGE, WR_COMMIT});

endmodule

// File: shapi_dev_regs.sv
// standard device space with identity words, status and control read values and scratch register
`timescale 1ns/1ps
`include "shapi_cfg.svh"

module shapi_dev_regs
    import shapi_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        commit_i,
    input  shapi_addr_t commit_addr_i,
    input  shapi_data_t commit_data_i,
    input  shapi_addr_t rd_addr_i,
    output shapi_data_t dev_rd_data_o,
    output logic        dev_hit_o
);

    localparam shapi_addr_t SCRATCH_ADDR = 11'h00F;

    shapi_data_t scratch_r;

    // --------------------------------------------------
    // scratch register
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            scratch_r <= `SHAPI_SCRATCH_RST;
        else if (commit_i && commit_addr_i == SCRATCH_ADDR)
            scratch_r <= commit_data_i;
    end

    // --------------------------------------------------
    // read decode
    // --------------------------------------------------
    always_comb
    begin
        dev_hit_o = 1'b1;
        case (rd_addr_i)
            11'h000: dev_rd_data_o = `SHAPI_DEV_MAGIC;
            11'h001: dev_rd_data_o = `SHAPI_DEV_VERSION;
            11'h002: dev_rd_data_o = `SHAPI_DEV_HW_ID;
            11'h003: dev_rd_data_o = `SHAPI_DEV_FW_ID;
            11'h004: dev_rd_data_o = `SHAPI_DEV_FW_VER;
            11'h005: dev_rd_data_o = `SHAPI_DEV_TSTAMP;
            11'h006: dev_rd_data_o = `SHAPI_DEV_NAME1;
            11'h007: dev_rd_data_o = `SHAPI_DEV_NAME2;
            11'h008: dev_rd_data_o = `SHAPI_DEV_NAME3;
            11'h009: dev_rd_data_o = `SHAPI_DEV_CAPAB;
            // status and control keep the capabilities layout and read zero
            11'h00A, 11'h00B: dev_rd_data_o = '0;
            SCRATCH_ADDR: dev_rd_data_o = scratch_r;
            default:
            begin
                dev_rd_data_o = '0;
                dev_hit_o     = 1'b0;   // left to the other space
            end
        endcase
    end

endmodule

// File: shapi_dma_regs.sv
// DMA module space: control, interrupt, size, trigger and buffer address registers with read decode
`timescale 1ns/1ps
`include "shapi_cfg.svh"

module shapi_dma_regs
    import shapi_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    commit_i,
    input  shapi_addr_t                             commit_addr_i,
    input  shapi_data_t                             commit_data_i,
    input  shapi_addr_t                             rd_addr_i,
    input  shapi_data_t                             status_i,
    output shapi_data_t                             dma_rd_data_o,
    output logic                                    dma_hit_o,
    output shapi_data_t                             control_o,
    output logic [`SHAPI_TRIG_CH*`SHAPI_TRIG_W-1:0] trigger_level_o,
    output logic [`SHAPI_DMA_SIZE_W-1:0]            dma_size_o,
    output shapi_data_t                             dma_ha_ch0_o,
    output shapi_data_t                             dma_ha_ch1_o
);

    logic [1:0]                  mod_ctrl_r;         // {full, soft} reset
    shapi_data_t                 flag_clr_r;
    shapi_data_t                 int_mask_r;
    shapi_data_t                 control_r;
    logic [`SHAPI_DMA_SIZE_W-1:0] size_r;
    shapi_data_t                 buf_addr_r [`SHAPI_NUM_BUF];
    shapi_data_t                 ha_ch1_r;
    logic [`SHAPI_TRIG_W-1:0]    trig_r [`SHAPI_TRIG_CH];

    shapi_addr_t wr_off;     // offsets into module space
    shapi_addr_t rd_off;
    logic        wr_in;      // address falls inside the 64 word window
    logic        rd_in;
    logic        rd_dec;     // offset is mapped
    logic        trig_wr;

    // below the base the offset wraps high, so one compare covers both sides
    assign wr_off  = commit_addr_i - `SHAPI_MOD_DMA_OFF;
    assign rd_off  = rd_addr_i - `SHAPI_MOD_DMA_OFF;
    assign wr_in   = wr_off < 11'h040;
    assign rd_in   = rd_off < 11'h040;
    assign trig_wr = commit_i && wr_in && wr_off[5:2] == 4'hC;   // 0x30..0x33

    // --------------------------------------------------
    // register writes
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mod_ctrl_r <= '0;
            flag_clr_r <= '0;
            int_mask_r <= '0;
            control_r  <= '0;
            size_r     <= '0;
            ha_ch1_r   <= '0;
            for (int i = 0; i < `SHAPI_NUM_BUF; i++)
                buf_addr_r[i] <= '0;
            for (int i = 0; i < `SHAPI_TRIG_CH; i++)
                trig_r[i] <= '0;
        end
        else if (commit_i && wr_in)
        begin
            case (wr_off[5:0])
                6'h08: mod_ctrl_r <= commit_data_i[31:30];
                6'h0A: flag_clr_r <= commit_data_i;
                6'h0B: int_mask_r <= commit_data_i;
                6'h11: control_r  <= commit_data_i;
                6'h12: size_r     <= commit_data_i[`SHAPI_DMA_SIZE_W-1:0];   // byte size
                6'h20, 6'h21, 6'h22, 6'h23,
                6'h24, 6'h25, 6'h26, 6'h27:
                    buf_addr_r[wr_off[2:0]] <= commit_data_i;
                6'h28: ha_ch1_r   <= commit_data_i;
                6'h30, 6'h31, 6'h32, 6'h33:
                    trig_r[wr_off[1:0]] <= commit_data_i[`SHAPI_TRIG_W-1:0];
                default: ;   // read-only or unmapped
            endcase
        end
    end

    // --------------------------------------------------
    // read decode
    // --------------------------------------------------
    always_comb
    begin
        rd_dec = 1'b1;
        case (rd_off[5:0])
            6'h00: dma_rd_data_o = `SHAPI_MOD_MAGIC;
            6'h01: dma_rd_data_o = `SHAPI_MOD_VERSION;
            6'h02: dma_rd_data_o = `SHAPI_MOD_FW_ID;
            6'h03: dma_rd_data_o = `SHAPI_MOD_FW_VER;
            6'h04: dma_rd_data_o = `SHAPI_MOD_NAME1;
            6'h05: dma_rd_data_o = `SHAPI_MOD_NAME2;
            6'h06: dma_rd_data_o = `SHAPI_MOD_CAPAB;
            6'h07: dma_rd_data_o = '0;                   // module status
            6'h08: dma_rd_data_o = {mod_ctrl_r, 30'h0};
            6'h09: dma_rd_data_o = `SHAPI_MOD_INT_ID;
            6'h0A: dma_rd_data_o = flag_clr_r;
            6'h0B: dma_rd_data_o = int_mask_r;
            6'h0C, 6'h0D: dma_rd_data_o = '0;            // flag and active
            6'h10: dma_rd_data_o = status_i;
            6'h11: dma_rd_data_o = control_r;
            6'h12: dma_rd_data_o = {{(`SHAPI_DATA_W-`SHAPI_DMA_SIZE_W){1'b0}}, size_r};
            6'h13: dma_rd_data_o = `SHAPI_MOD_MAX_BYTES;
            6'h14: dma_rd_data_o = `SHAPI_MOD_TLP_PLD;
            6'h20: dma_rd_data_o = buf_addr_r[0];
            default:
            begin
                dma_rd_data_o = '0;
                rd_dec        = 1'b0;
            end
        endcase
    end

    assign dma_hit_o = rd_in & rd_dec;

    // --------------------------------------------------
    // field outputs
    // --------------------------------------------------
    assign control_o    = control_r;
    assign dma_size_o   = size_r;
    assign dma_ha_ch1_o = ha_ch1_r;
    // channel 0 follows the current-buffer field
    assign dma_ha_ch0_o = buf_addr_r[status_i[$clog2(`SHAPI_NUM_BUF)-1:0]];

    for (genvar ch = 0; ch < `SHAPI_TRIG_CH; ch++)
    begin : g_trig
        assign trigger_level_o[ch*`SHAPI_TRIG_W +: `SHAPI_TRIG_W] = trig_r[ch];

        // a trigger commit leaves the other channels alone
        a_trig_isolated: assert property (@(posedge clk) disable iff (!rst_n)
            (trig_wr && wr_off[1:0] != ch) |=> $stable(trig_r[ch]));
    end

endmodule

// File: shapi_read_mux.sv
// read mux with space select, unmapped value and read byte lanes
`timescale 1ns/1ps
`include "shapi_cfg.svh"

module shapi_read_mux
    import shapi_pkg::*;
(
    input  shapi_addr_t rd_addr_i,
    input  shapi_be_t   rd_be_i,
    input  shapi_data_t dev_rd_data_i,
    input  logic        dev_hit_i,
    input  shapi_data_t dma_rd_data_i,
    input  logic        dma_hit_i,
    output shapi_data_t rd_data_o
);

    shapi_data_t raw;

    // unmapped word echoes its own address
    always_comb
    begin
        if (dev_hit_i)
            raw = dev_rd_data_i;
        else if (dma_hit_i)
            raw = dma_rd_data_i;
        else
            raw = {{(`SHAPI_DATA_W-`SHAPI_ADDR_W){1'b0}}, rd_addr_i};
    end

    // --------------------------------------------------
    // reversed and gated read lanes
    // --------------------------------------------------
    assign rd_data_o = {rd_be_i[0] ? raw[7:0]   : 8'h00,
                        rd_be_i[1] ? raw[15:8]  : 8'h00,
                        rd_be_i[2] ? raw[23:16] : 8'h00,
                        rd_be_i[3] ? raw[31:24] : 8'h00};

    // the two address maps must not overlap
    always_comb
    begin
        a_one_space: assert #0 (!(dev_hit_i && dma_hit_i));
    end

endmodule

// File: shapi_regs_top.sv
// top level of the SHAPI register block: write controller, both spaces and read mux
`timescale 1ns/1ps
`include "shapi_cfg.svh"

module shapi_regs_top
    import shapi_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    rst_n,
    // write port
    input  logic                                    wr_en_i,
    input  shapi_addr_t                             wr_addr_i,
    input  shapi_be_t                               wr_be_i,
    input  shapi_data_t                             wr_data_i,
    output logic                                    wr_busy_o,
    // read port
    input  shapi_addr_t                             rd_addr_i,
    input  shapi_be_t                               rd_be_i,
    output shapi_data_t                             rd_data_o,
    // dma side
    input  shapi_data_t                             status_i,
    output shapi_data_t                             control_o,
    output logic [`SHAPI_TRIG_CH*`SHAPI_TRIG_W-1:0] trigger_level_o,
    output logic [`SHAPI_DMA_SIZE_W-1:0]            dma_size_o,
    output shapi_data_t                             dma_ha_ch0_o,
    output shapi_data_t                             dma_ha_ch1_o
);

    logic        commit;
    shapi_addr_t commit_addr;
    shapi_data_t commit_data;
    shapi_data_t dev_rd_data;
    logic        dev_hit;
    shapi_data_t dma_rd_data;
    logic        dma_hit;

    shapi_write_ctrl u_write_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en_i       (wr_en_i),
        .wr_addr_i     (wr_addr_i),
        .wr_be_i       (wr_be_i),
        .wr_data_i     (wr_data_i),
        .wr_busy_o     (wr_busy_o),
        .commit_o      (commit),
        .commit_addr_o (commit_addr),
        .commit_data_o (commit_data)
    );

    shapi_dev_regs u_dev_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_i      (commit),
        .commit_addr_i (commit_addr),
        .commit_data_i (commit_data),
        .rd_addr_i     (rd_addr_i),
        .dev_rd_data_o (dev_rd_data),
        .dev_hit_o     (dev_hit)
    );

    shapi_dma_regs u_dma_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .commit_i        (commit),
        .commit_addr_i   (commit_addr),
        .commit_data_i   (commit_data),
        .rd_addr_i       (rd_addr_i),
        .status_i        (status_i),
        .dma_rd_data_o   (dma_rd_data),
        .dma_hit_o       (dma_hit),
        .control_o       (control_o),
        .trigger_level_o (trigger_level_o),
        .dma_size_o      (dma_size_o),
        .dma_ha_ch0_o    (dma_ha_ch0_o),
        .dma_ha_ch1_o    (dma_ha_ch1_o)
    );

    shapi_read_mux u_read_mux (
        .rd_addr_i     (rd_addr_i),
        .rd_be_i       (rd_be_i),
        .dev_rd_data_i (dev_rd_data),
        .dev_hit_i     (dev_hit),
        .dma_rd_data_i (dma_rd_data),
        .dma_hit_i     (dma_hit),
        .rd_data_o     (rd_data_o)
    );

endmodule

// File: tb_shapi_regs.sv
// random testbench for the SHAPI register block with register model, check task and timeouts
`timescale 1ns/1ps
`include "shapi_cfg.svh"

module tb_shapi_regs
    import shapi_pkg::*;
();

    localparam shapi_addr_t DMA       = `SHAPI_MOD_DMA_OFF;
    localparam shapi_addr_t SCRATCH   = 11'h00F;
    localparam shapi_data_t SIZE_MASK = (32'h1 << `SHAPI_DMA_SIZE_W) - 32'h1;
    localparam shapi_data_t TRIG_MASK = (32'h1 << `SHAPI_TRIG_W) - 32'h1;
    localparam int          TIMEOUT   = 20;     // cycles allowed per wait

    logic        clk;
    logic        rst_n;
    logic        wr_en_i;
    shapi_addr_t wr_addr_i;
    shapi_be_t   wr_be_i;
    shapi_data_t wr_data_i;
    logic        wr_busy_o;
    shapi_addr_t rd_addr_i;
    shapi_be_t   rd_be_i;
    shapi_data_t rd_data_o;
    shapi_data_t status_i;
    shapi_data_t control_o;
    logic [`SHAPI_TRIG_CH*`SHAPI_TRIG_W-1:0] trigger_level_o;
    logic [`SHAPI_DMA_SIZE_W-1:0]            dma_size_o;
    shapi_data_t dma_ha_ch0_o;
    shapi_data_t dma_ha_ch1_o;

    shapi_data_t model [2048];      // expected contents per word address
    shapi_addr_t rw_regs [7];       // read/write targets for readback
    integer      seed;

    shapi_regs_top UUT (
        .clk(clk), .rst_n(rst_n),
        .wr_en_i(wr_en_i), .wr_addr_i(wr_addr_i), .wr_be_i(wr_be_i),
        .wr_data_i(wr_data_i), .wr_busy_o(wr_busy_o),
        .rd_addr_i(rd_addr_i), .rd_be_i(rd_be_i), .rd_data_o(rd_data_o),
        .status_i(status_i), .control_o(control_o), .trigger_level_o(trigger_level_o),
        .dma_size_o(dma_size_o), .dma_ha_ch0_o(dma_ha_ch0_o), .dma_ha_ch1_o(dma_ha_ch1_o)
    );

    always #2 clk = ~clk;   // 4 ns period

    // --------------------------------------------------
    // model helpers
    // --------------------------------------------------
    function automatic shapi_data_t rand_word();
        rand_word = $random(seed);
    endfunction

    // merged lane l takes payload byte 3-l when enabled
    function automatic shapi_data_t merge_bytes(input shapi_data_t d, input shapi_be_t be);
        shapi_data_t m;
        m = '0;
        for (int l = 0; l < 4; l++)
            if (be[l])
                m[l*8 +: 8] = d[(3-l)*8 +: 8];
        return m;
    endfunction

    // raw byte k lands in output lane 3-k, gated by rd_be bit k
    function automatic shapi_data_t read_lanes(input shapi_data_t raw, input shapi_be_t be);
        shapi_data_t o;
        o = '0;
        for (int k = 0; k < 4; k++)
            if (be[k])
                o[(3-k)*8 +: 8] = raw[k*8 +: 8];
        return o;
    endfunction

    function automatic bit is_readable(input shapi_addr_t a);
        shapi_addr_t off;
        off = a - DMA;  // wraps high below the base
        return (a <= 11'h00B) || (a == SCRATCH)
            || (off inside {[11'h000:11'h00D], [11'h010:11'h014], 11'h020});
    endfunction

    function automatic shapi_data_t expected_raw(input shapi_addr_t a, input shapi_data_t st);
        if (!is_readable(a))
            return {21'h0, a};              // unmapped echoes address
        else if (a == DMA + 11'h010)
            return st;
        else
            return model[a];
    endfunction

    // store with the width of the target field
    function automatic void apply_write(input shapi_addr_t a, input shapi_data_t m);
        shapi_addr_t off;
        off = a - DMA;
        if (a == SCRATCH)
            model[a] = m;
        else if (off == 11'h008)
            model[a] = {m[31:30], 30'h0};   // module control bits only
        else if (off inside {11'h00A, 11'h00B, 11'h011, [11'h020:11'h028]})
            model[a] = m;
        else if (off == 11'h012)
            model[a] = m & SIZE_MASK;
        else if (off inside {[11'h030:11'h033]})
            model[a] = m & TRIG_MASK;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < 2048; i++)
            model[shapi_addr_t'(i)] = '0;
        model[11'h000] = `SHAPI_DEV_MAGIC;
        model[11'h001] = `SHAPI_DEV_VERSION;
        model[11'h002] = `SHAPI_DEV_HW_ID;
        model[11'h003] = `SHAPI_DEV_FW_ID;
        model[11'h004] = `SHAPI_DEV_FW_VER;
        model[11'h005] = `SHAPI_DEV_TSTAMP;
        model[11'h006] = `SHAPI_DEV_NAME1;
        model[11'h007] = `SHAPI_DEV_NAME2;
        model[11'h008] = `SHAPI_DEV_NAME3;
        model[11'h009] = `SHAPI_DEV_CAPAB;
        model[SCRATCH] = `SHAPI_SCRATCH_RST;
        model[DMA + 11'h000] = `SHAPI_MOD_MAGIC;
        model[DMA + 11'h001] = `SHAPI_MOD_VERSION;
        model[DMA + 11'h002] = `SHAPI_MOD_FW_ID;
        model[DMA + 11'h003] = `SHAPI_MOD_FW_VER;
        model[DMA + 11'h004] = `SHAPI_MOD_NAME1;
        model[DMA + 11'h005] = `SHAPI_MOD_NAME2;
        model[DMA + 11'h006] = `SHAPI_MOD_CAPAB;
        model[DMA + 11'h009] = `SHAPI_MOD_INT_ID;
        model[DMA + 11'h013] = `SHAPI_MOD_MAX_BYTES;
        model[DMA + 11'h014] = `SHAPI_MOD_TLP_PLD;
    endfunction

    // --------------------------------------------------
    // bus tasks and checks
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (wr_busy_o)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT)
            begin
                $display("timeout: wr_busy_o stayed high after a write");
                $display("TESTBENCH FAILED");
                $fatal(1, "write did not complete");
            end
        end
    endtask

    task automatic write_reg(input shapi_addr_t a, input shapi_be_t be, input shapi_data_t d);
        @(negedge clk);
        wr_en_i   = 1'b1;
        wr_addr_i = a;
        wr_be_i   = be;
        wr_data_i = d;
        @(negedge clk);         // accepted on the edge between
        wr_en_i = 1'b0;
        wait_idle();
        apply_write(a, merge_bytes(d, be));
    endtask

    task automatic read_check(input shapi_addr_t a, input shapi_be_t be);
        @(negedge clk);
        rd_addr_i = a;
        rd_be_i   = be;
        #1;                     // combinational path settles mid phase
        check_value($sformatf("rd_data_o[%03h]", a), 64'(rd_data_o),
                    64'(read_lanes(expected_raw(a, status_i), be)));
    endtask

    task automatic check_fields();
        check_value("trigger_level_o", trigger_level_o,
                    {model[DMA + 11'h033][15:0], model[DMA + 11'h032][15:0],
                     model[DMA + 11'h031][15:0], model[DMA + 11'h030][15:0]});
        check_value("dma_size_o", 64'(dma_size_o), 64'(model[DMA + 11'h012]));
        check_value("dma_ha_ch1_o", 64'(dma_ha_ch1_o), 64'(model[DMA + 11'h028]));
        check_value("control_o", 64'(control_o), 64'(model[DMA + 11'h011]));
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial
    begin
        shapi_data_t r;
        shapi_data_t d;
        shapi_addr_t a;
        logic [2:0]  idx;

        clk       = 1'b0;
        rst_n     = 1'b0;
        wr_en_i   = 1'b0;
        wr_addr_i = '0;
        wr_be_i   = '0;
        wr_data_i = '0;
        rd_addr_i = '0;
        rd_be_i   = '0;
        status_i  = '0;
        seed      = 32'hce6b_e88c;
        rw_regs   = '{SCRATCH, DMA + 11'h011, DMA + 11'h00A, DMA + 11'h00B,
                      DMA + 11'h008, DMA + 11'h012, DMA + 11'h020};
        model_reset();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_fields();     // all fields zero out of reset
        check_value("dma_ha_ch0_o", 64'(dma_ha_ch0_o), 64'h0);
        check_value("wr_busy_o", 64'(wr_busy_o), 64'h0);
        read_check(SCRATCH, 4'hF);

        // identity words with full enables
        for (int i = 0; i < 12; i++)
            read_check(shapi_addr_t'(i), 4'hF);
        for (int i = 0; i <= 'h14; i++)
            read_check(DMA + shapi_addr_t'(i), 4'hF);

        // random merge and readback
        repeat (40)
        begin
            r   = rand_word();
            idx = 3'(r % 7);
            d   = rand_word();
            write_reg(rw_regs[idx], r[11:8], d);
            read_check(rw_regs[idx], r[15:12]);
        end

        // trigger, ch1 and size fields
        repeat (30)
        begin
            r   = rand_word();
            idx = 3'(r % 6);
            if (idx < 3'd4)
                a = DMA + 11'h030 + 11'(idx);
            else if (idx == 3'd4)
                a = DMA + 11'h028;
            else
                a = DMA + 11'h012;
            write_reg(a, r[11:8], rand_word());
            check_fields();
        end

        // buffer select by status_i[2:0]
        for (int i = 0; i < `SHAPI_NUM_BUF; i++)
        begin
            r = rand_word();
            write_reg(DMA + 11'h020 + shapi_addr_t'(i), r[3:0], rand_word());
        end
        repeat (16)
        begin
            @(negedge clk);
            status_i = rand_word();
            #1;
            check_value("dma_ha_ch0_o", 64'(dma_ha_ch0_o),
                        64'(model[DMA + 11'h020 + 11'(status_i[2:0])]));
            r = rand_word();
            read_check(DMA + 11'h010, r[3:0]);
        end

        // second strobe during commit is dropped
        d = rand_word();
        r = rand_word();
        @(negedge clk);
        wr_en_i   = 1'b1;
        wr_addr_i = SCRATCH;
        wr_be_i   = 4'hF;
        wr_data_i = d;
        @(negedge clk);
        wr_en_i = 1'b0;
        @(negedge clk);     // commit state
        check_value("wr_busy_o", 64'(wr_busy_o), 64'h1);
        wr_en_i   = 1'b1;
        wr_addr_i = DMA + 11'h011;
        wr_data_i = r;
        @(negedge clk);
        wr_en_i = 1'b0;
        wait_idle();
        apply_write(SCRATCH, merge_bytes(d, 4'hF));
        read_check(SCRATCH, 4'hF);
        read_check(DMA + 11'h011, 4'hF);
        check_fields();

        // unmapped gaps and random addresses
        read_check(11'h00C, 4'hF);
        read_check(11'h00E, 4'hF);
        read_check(DMA + 11'h00E, 4'hF);
        read_check(DMA + 11'h021, 4'hF);
        read_check(11'h080, 4'hF);
        repeat (24)
        begin
            r = rand_word();
            read_check(r[10:0], r[15:12]);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
shapi_pkg.sv
shapi_write_ctrl.sv
shapi_dev_regs.sv
shapi_dma_regs.sv
shapi_read_mux.sv
shapi_regs_top.sv
tb_shapi_regs.sv

// File: Makefile
# Verilator flow for the SHAPI register block testbench
TOP := tb_shapi_regs

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
